// ==== controlDecoder.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module controlDecoder
	import cpuPkg::*;
(
	input  instrWord_t         instr,
	input  logic [`DATA_W-1:0] pcPlus4,
	output ctrl_t              ctrl,
	output logic [`DATA_W-1:0] imm,
	output logic               jump,
	output logic [`DATA_W-1:0] jumpTarget
);
	logic zeroExt;

	// Register-writing ALU op on rs and the immediate
	function automatic ctrl_t immAlu(input logic [`ALU_OP_W-1:0] op);
		immAlu = '0;
		immAlu.regWrite = 1'b1;
		immAlu.aluSrcImm = 1'b1;
		immAlu.aluOp = op;
	endfunction

	always_comb begin
		ctrl = '0;
		jump = 1'b0;
		zeroExt = 1'b0;
		case (instr.r.opcode)
			`OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				case (instr.r.funct)
					`FN_ADD, `FN_ADDU: ctrl.aluOp = `ALU_ADD; // no overflow trap
					`FN_SUB, `FN_SUBU: ctrl.aluOp = `ALU_SUB;
					`FN_AND: ctrl.aluOp = `ALU_AND;
					`FN_OR: ctrl.aluOp = `ALU_OR;
					`FN_XOR: ctrl.aluOp = `ALU_XOR;
					`FN_NOR: ctrl.aluOp = `ALU_NOR;
					`FN_SLT: ctrl.aluOp = `ALU_SLT;
					default: ctrl.regWrite = 1'b0; // Also the all-zero bubble word
				endcase
			end
			`OP_ADDI, `OP_ADDIU: ctrl = immAlu(`ALU_ADD);
			`OP_SLTI: ctrl = immAlu(`ALU_SLT);
			`OP_LUI: ctrl = immAlu(`ALU_LUI);
			`OP_ANDI, `OP_ORI: begin
				ctrl = immAlu(instr.i.opcode == `OP_ANDI ? `ALU_AND : `ALU_OR);
				zeroExt = 1'b1; // Logical immediates are unsigned
			end
			`OP_LW: begin
				ctrl = immAlu(`ALU_ADD);
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			`OP_SW: begin
				ctrl = immAlu(`ALU_ADD);
				ctrl.regWrite = 1'b0;
				ctrl.memWrite = 1'b1;
			end
			`OP_BEQ: ctrl.branchEq = 1'b1;
			`OP_BNE: ctrl.branchNe = 1'b1;
			`OP_J: jump = 1'b1; // Taken in ID, no EX work
			default: ctrl = '0;
		endcase
	end

	assign imm = zeroExt ? {{(`DATA_W-16){1'b0}}, instr.i.imm}
		: {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};

	// Region bits come from the slot after the jump
	assign jumpTarget = {pcPlus4[`DATA_W-1:28], instr.j.target, 2'b00};
endmodule

`default_nettype wire

// ==== cpuPkg.sv ====
`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;
	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_ADDR_W-1:0] rs, rt, rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_ADDR_W-1:0] rs, rt;
		logic [15:0] imm;
	} iFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} jFields_t;

	// One fetched word, read as whichever format the opcode says
	typedef union packed {
		rFields_t r;
		iFields_t i;
		jFields_t j;
	} instrWord_t;

	typedef struct packed {
		logic regWrite;
		logic memRead, memWrite, memToReg;
		logic aluSrcImm; // B operand is the immediate
		logic [`ALU_OP_W-1:0] aluOp;
		logic branchEq, branchNe;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`DATA_W-1:0] pcPlus4, readData1, readData2, imm;
		logic [`REG_ADDR_W-1:0] rs, rt, dest;
	} idEx_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`DATA_W-1:0] aluResult, storeData;
		logic [`REG_ADDR_W-1:0] dest;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		logic [`DATA_W-1:0] data;
		logic [`REG_ADDR_W-1:0] dest;
	} memWb_t;

	// Write-back strobe
	typedef struct packed {
		logic valid;
		logic [`REG_ADDR_W-1:0] regIdx;
		logic [`DATA_W-1:0] data;
	} regWrite_t;

	typedef struct packed {
		logic valid;
		logic [`DATA_W-1:0] addr, data; // byte address
	} memWrite_t;
endpackage

`default_nettype wire

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define DATA_W     32
`define REG_ADDR_W 5
`define DMEM_WORDS 256
`define RESET_PC   32'h0000_0000

// Major opcodes
`define OP_RTYPE 6'd0
`define OP_J     6'd2
`define OP_BEQ   6'd4
`define OP_BNE   6'd5
`define OP_ADDI  6'd8
`define OP_ADDIU 6'd9
`define OP_SLTI  6'd10
`define OP_ANDI  6'd12
`define OP_ORI   6'd13
`define OP_LUI   6'd15
`define OP_LW    6'd35
`define OP_SW    6'd43

// R-format function field
`define FN_ADD  6'd32
`define FN_ADDU 6'd33
`define FN_SUB  6'd34
`define FN_SUBU 6'd35
`define FN_AND  6'd36
`define FN_OR   6'd37
`define FN_XOR  6'd38
`define FN_NOR  6'd39
`define FN_SLT  6'd42

`define ALU_OP_W 3
`define ALU_AND  3'd0
`define ALU_OR   3'd1
`define ALU_ADD  3'd2
`define ALU_XOR  3'd3
`define ALU_NOR  3'd4
`define ALU_LUI  3'd5
`define ALU_SUB  3'd6
`define ALU_SLT  3'd7

// EX operand source
`define FWD_W   2
`define FWD_REG 2'd0
`define FWD_MEM 2'd1
`define FWD_WB  2'd2

`endif

// ==== dataMemory.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module dataMemory (
	input  logic               clk,
	input  logic [`DATA_W-1:0] addr,
	input  logic [`DATA_W-1:0] writeData,
	input  logic               write,
	output logic [`DATA_W-1:0] readData
);
	localparam int idxWidth = $clog2(`DMEM_WORDS);

	logic [`DATA_W-1:0] mem [`DMEM_WORDS];
	logic [idxWidth-1:0] wordIdx;

	assign wordIdx = addr[idxWidth+1:2]; // Upper address bits wrap

	always_ff @(posedge clk) begin
		if (write)
			mem[wordIdx] <= writeData;
	end

	assign readData = mem[wordIdx];

	// Store addresses come from the EX adder through EX/MEM
	assert property (@(posedge clk) write |-> addr[1:0] == 2'b00)
		else $error("dataMemory: unaligned store to %h", addr);
endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module executeStage
	import cpuPkg::*;
(
	input  idEx_t              idEx,
	input  logic [`FWD_W-1:0]  fwdA,
	input  logic [`FWD_W-1:0]  fwdB,
	input  logic [`DATA_W-1:0] memValue,
	input  logic [`DATA_W-1:0] wbValue,
	output logic [`DATA_W-1:0] aluResult,
	output logic [`DATA_W-1:0] storeData,
	output logic               branchTaken,
	output logic [`DATA_W-1:0] branchTarget
);
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluB;
	logic operandsEqual;

	function automatic logic [`DATA_W-1:0] fwdMux(input logic [`FWD_W-1:0] sel,
			input logic [`DATA_W-1:0] regValue);
		case (sel)
			`FWD_MEM: return memValue;
			`FWD_WB: return wbValue;
			default: return regValue;
		endcase
	endfunction

	always_comb begin
		opA = fwdMux(fwdA, idEx.readData1);
		opB = fwdMux(fwdB, idEx.readData2);
	end

	assign storeData = opB; // SW data is the forwarded rt
	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			`ALU_AND: aluResult = opA & aluB;
			`ALU_OR: aluResult = opA | aluB;
			`ALU_ADD: aluResult = opA + aluB;
			`ALU_XOR: aluResult = opA ^ aluB;
			`ALU_NOR: aluResult = ~(opA | aluB);
			`ALU_LUI: aluResult = {aluB[15:0], 16'h0000};
			`ALU_SUB: aluResult = opA - aluB;
			`ALU_SLT: aluResult = {{(`DATA_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: aluResult = '0;
		endcase
	end

	// Branches compare rs and rt after forwarding
	assign operandsEqual = (opA == opB);
	assign branchTaken = (idEx.ctrl.branchEq && operandsEqual) ||
		(idEx.ctrl.branchNe && !operandsEqual);
	assign branchTarget = idEx.pcPlus4 + (idEx.imm << 2);

	// A redirect only ever comes from a pure branch
	always_comb assert (!branchTaken || ((idEx.ctrl.branchEq ^ idEx.ctrl.branchNe) &&
			!idEx.ctrl.regWrite && !idEx.ctrl.memWrite))
		else $error("executeStage: branch taken with control %h", idEx.ctrl);
endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module hazardUnit
	import cpuPkg::*;
(
	input  instrWord_t             idInstr,
	input  logic [`REG_ADDR_W-1:0] exRs,
	input  logic [`REG_ADDR_W-1:0] exRt,
	input  logic [`REG_ADDR_W-1:0] exDest,
	input  logic                   exMemRead,
	input  logic [`REG_ADDR_W-1:0] memDest,
	input  logic                   memRegWrite,
	input  logic [`REG_ADDR_W-1:0] wbDest,
	input  logic                   wbRegWrite,
	output logic [`FWD_W-1:0]      fwdA,
	output logic [`FWD_W-1:0]      fwdB,
	output logic                   stall
);
	logic memValid;
	logic wbValid;

	assign memValid = memRegWrite && (memDest != '0);
	assign wbValid = wbRegWrite && (wbDest != '0);

	// MEM holds the younger result so it wins
	function automatic logic [`FWD_W-1:0] fwdSel(input logic [`REG_ADDR_W-1:0] src);
		if (memValid && (memDest == src))
			return `FWD_MEM;
		if (wbValid && (wbDest == src))
			return `FWD_WB;
		return `FWD_REG;
	endfunction

	always_comb begin
		fwdA = fwdSel(exRs);
		fwdB = fwdSel(exRt);
	end

	// Load data only exists after MEM, so its consumer waits one cycle
	assign stall = exMemRead && (exDest != '0) &&
		((exDest == idInstr.i.rs) || (exDest == idInstr.i.rt));
endmodule

`default_nettype wire

// ==== mipsPipeline.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module mipsPipeline
	import cpuPkg::*;
(
	input  logic               clk,
	input  logic               reset,
	output logic [`DATA_W-1:0] imemAddr,
	input  instrWord_t         imemData,
	output regWrite_t          retire,
	output memWrite_t          store
);
	logic [`DATA_W-1:0] pc, pcPlus4, ifIdPcPlus4;
	instrWord_t ifIdInstr;
	ctrl_t idCtrl;
	logic [`DATA_W-1:0] idImm, idJumpTarget, idReadData1, idReadData2;
	logic [`REG_ADDR_W-1:0] idDest;
	logic idJump;
	logic jumpTaken;
	idEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;
	logic [`FWD_W-1:0] fwdA, fwdB;
	logic stall;
	logic [`DATA_W-1:0] aluResult, storeData, branchTarget, memReadData;
	logic branchTaken;

	assign pcPlus4 = pc + 32'd4;
	assign imemAddr = pc;
	assign jumpTaken = idJump && !stall; // A stalled J retries next cycle

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (branchTaken)
			pc <= branchTarget; // Older instruction wins over a J in ID
		else if (jumpTaken)
			pc <= idJumpTarget;
		else if (!stall)
			pc <= pcPlus4;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdInstr <= imemData;
			ifIdPcPlus4 <= pcPlus4;
		end
		if (reset || branchTaken || jumpTaken)
			ifIdInstr <= '0; // Zero word decodes to a bubble
	end

	controlDecoder decoder_i (.instr(ifIdInstr), .pcPlus4(ifIdPcPlus4), .ctrl(idCtrl),
		.imm(idImm), .jump(idJump), .jumpTarget(idJumpTarget));

	registerFile regFile_i (.clk(clk), .reset(reset), .readAddr1(ifIdInstr.r.rs),
		.readAddr2(ifIdInstr.r.rt), .readData1(idReadData1), .readData2(idReadData2),
		.wb(memWb));

	assign idDest = (ifIdInstr.r.opcode == `OP_RTYPE) ? ifIdInstr.r.rd : ifIdInstr.i.rt;

	always_ff @(posedge clk) begin
		idEx <= '{ctrl: idCtrl, pcPlus4: ifIdPcPlus4, readData1: idReadData1,
			readData2: idReadData2, imm: idImm, rs: ifIdInstr.r.rs, rt: ifIdInstr.r.rt,
			dest: idDest};
		if (reset || stall || branchTaken)
			idEx.ctrl <= '0;
	end

	hazardUnit hazard_i (.idInstr(ifIdInstr), .exRs(idEx.rs), .exRt(idEx.rt),
		.exDest(idEx.dest), .exMemRead(idEx.ctrl.memRead), .memDest(exMem.dest),
		.memRegWrite(exMem.ctrl.regWrite), .wbDest(memWb.dest),
		.wbRegWrite(memWb.regWrite), .fwdA(fwdA), .fwdB(fwdB), .stall(stall));

	executeStage execute_i (.idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
		.memValue(exMem.aluResult), .wbValue(memWb.data), .aluResult(aluResult),
		.storeData(storeData), .branchTaken(branchTaken), .branchTarget(branchTarget));

	always_ff @(posedge clk) begin
		exMem <= '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: storeData,
			dest: idEx.dest};
		if (reset)
			exMem.ctrl <= '0;
	end

	dataMemory dmem_i (.clk(clk), .addr(exMem.aluResult), .writeData(exMem.storeData),
		.write(exMem.ctrl.memWrite), .readData(memReadData));

	always_ff @(posedge clk) begin
		memWb <= '{regWrite: exMem.ctrl.regWrite,
			data: exMem.ctrl.memToReg ? memReadData : exMem.aluResult, dest: exMem.dest};
		if (reset)
			memWb.regWrite <= 1'b0;
	end

	always_comb begin
		retire.valid = memWb.regWrite && (memWb.dest != '0);
		retire.regIdx = memWb.dest;
		retire.data = memWb.data;
		store.valid = exMem.ctrl.memWrite;
		store.addr = exMem.aluResult;
		store.data = exMem.storeData;
	end

	// A load-use stall and a branch never sit in ID/EX together
	assert property (@(posedge clk) disable iff (reset) !(stall && branchTaken))
		else $error("mipsPipeline: stall with taken branch");
endmodule

`default_nettype wire

// ==== mipsPipeline_tb.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module mipsPipeline_tb
	import cpuPkg::*;
();
	logic clk;
	logic reset;
	logic [`DATA_W-1:0] imemAddr;
	regWrite_t retire;
	memWrite_t store;
	logic [31:0] rom [64];

	logic [`REG_ADDR_W-1:0] expRegIdx [$];
	logic [`DATA_W-1:0] expRegVal [$];
	logic [`DATA_W-1:0] expStAddr [$];
	logic [`DATA_W-1:0] expStData [$];
	int errors = 0;
	int passedTests = 0;
	int failedTests = 0;
	int midReset = 0;

	mipsPipeline dut_i (.clk(clk), .reset(reset), .imemAddr(imemAddr),
		.imemData(rom[imemAddr[7:2]]), .retire(retire), .store(store));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act)
			else begin
				$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
				errors++;
			end
	endtask

	// Each strobe is matched against the head of its own queue
	task automatic checkStrobes();
		if (retire.valid) begin
			assert (expRegIdx.size() != 0)
				else begin
					$display("unexpected write of %h to r%0d at %0t", retire.data,
						retire.regIdx, $time);
					errors++;
				end
			if (expRegIdx.size() != 0) begin
				checkValue("retire.regIdx", 32'(expRegIdx.pop_front()), 32'(retire.regIdx));
				checkValue("retire.data", expRegVal.pop_front(), retire.data);
			end
		end
		if (store.valid) begin
			assert (expStAddr.size() != 0)
				else begin
					$display("unexpected store to %h at %0t", store.addr, $time);
					errors++;
				end
			if (expStAddr.size() != 0) begin
				checkValue("store.addr", expStAddr.pop_front(), store.addr);
				checkValue("store.data", expStData.pop_front(), store.data);
			end
		end
	endtask

	task automatic holdReset();
		reset = 1'b1;
		repeat (2) begin
			@(negedge clk);
			assert (!retire.valid && !store.valid)
				else begin
					$display("a strobe was valid during reset at %0t", $time);
					errors++;
				end
			checkValue("imemAddr", `RESET_PC, imemAddr); // Fetch restarts at the reset PC
		end
		reset = 1'b0;
	endtask

	task automatic runTest(input string name);
		int cycles;
		int startErrors;
		startErrors = errors;
		holdReset();
		if (midReset > 0) begin
			repeat (midReset) @(negedge clk); // Events before the restart are ignored
			holdReset();
		end
		cycles = 0;
		while ((expRegIdx.size() + expStAddr.size()) > 0 && cycles < 300) begin
			@(negedge clk);
			checkStrobes();
			cycles++;
		end
		assert ((expRegIdx.size() + expStAddr.size()) == 0)
			else begin
				$display("timed out in %s waiting for %0d write and %0d store events", name,
					expRegIdx.size(), expStAddr.size());
				errors++;
			end
		repeat (20) begin
			@(negedge clk);
			checkStrobes();
		end
		expRegIdx.delete();
		expRegVal.delete();
		expStAddr.delete();
		expStData.delete();
		midReset = 0;
		if (errors == startErrors) begin
			passedTests++;
			$display("test %s passed", name);
		end else begin
			failedTests++;
			$display("test %s failed", name);
		end
	endtask

	initial begin
		int fd;
		int romIdx;
		string line;
		string tok;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		reset = 1'b1;
		romIdx = 0;
		fd = $fopen("pipeline_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				tok = "";
				void'($fgets(line, fd));
				void'($sscanf(line, "%s %h %h", tok, a, b));
				case (tok)
					"T": begin
						void'($sscanf(line, "%s %s", tok, name));
						@(negedge clk);
						reset = 1'b1;
						for (int i = 0; i < 64; i++)
							rom[i] = 32'h0800_0000 | 32'(i); // J to its own slot
						romIdx = 0;
					end
					"I": begin
						rom[romIdx] = a;
						romIdx++;
					end
					"R": begin
						expRegIdx.push_back(a[4:0]);
						expRegVal.push_back(b);
					end
					"S": begin
						expStAddr.push_back(a);
						expStData.push_back(b);
					end
					"X": midReset = int'(a);
					"E": runTest(name);
					default: ;
				endcase
			end
			$fclose(fd);
			$display("tests passed %0d, failed %0d, errors %0d", passedTests, failedTests,
				errors);
			if (errors == 0 && failedTests == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end
endmodule

`default_nettype wire

// ==== pipeline_stimulus.txt ====
# T name | I instruction word | R reg value (write-back) | S addr data (store)
# X cycles before a second reset | E runs the test, all numbers hex
T alu
I 20010005
I 2002FFFD
I 00221820
I 0041202A
I 00202827
I 3C061234
I 20000007
I 34C7FFFF
I 00224022
I 08000009
R 1 00000005
R 2 FFFFFFFD
R 3 00000002
R 4 00000001
R 5 FFFFFFFA
R 6 12340000
R 7 1234FFFF
R 8 00000008
E
T forward
I 20010001
I 00210820
I 00210820
I 20220003
I 00221820
I 30640006
I 00642826
I 08000007
R 1 00000001
R 1 00000002
R 1 00000004
R 2 00000007
R 3 0000000B
R 4 00000002
R 5 00000009
E
T loadstore
I 20010040
I 20020055
I AC220004
I 8C230004
I 00632020
I AC240008
I 08000006
R 1 00000040
R 2 00000055
S 00000044 00000055
R 3 00000055
R 4 000000AA
S 00000048 000000AA
E
T branch
I 20010001
I 10210002
I 20090BAD
I 20090BAD
I 14200002
I 20090BAD
I 20090BAD
I 10200001
I 20020002
I 0800000B
I 20090BAD
I 20030003
I 0800000C
R 1 00000001
R 2 00000002
R 3 00000003
E
T restart
I 20010001
I 00210820
I 00210820
I 20220003
I 08000004
X 6
R 1 00000001
R 1 00000002
R 1 00000004
R 2 00000007
E

// ==== registerFile.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module registerFile
	import cpuPkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`REG_ADDR_W-1:0] readAddr1,
	input  logic [`REG_ADDR_W-1:0] readAddr2,
	output logic [`DATA_W-1:0]     readData1,
	output logic [`DATA_W-1:0]     readData2,
	input  memWb_t                 wb
);
	logic [`DATA_W-1:0] regs [2**`REG_ADDR_W];
	logic writeEn;
	logic hit1;
	logic hit2;

	assign writeEn = wb.regWrite && (wb.dest != '0); // r0 stays zero

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**`REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// WB write in this cycle is visible to the ID read
	assign hit1 = writeEn && (wb.dest == readAddr1);
	assign hit2 = writeEn && (wb.dest == readAddr2);
	assign readData1 = hit1 ? wb.data : regs[readAddr1];
	assign readData2 = hit2 ? wb.data : regs[readAddr2];
endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module mipsPipeline_tb -o simv
./obj_dir/simv > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi

// ==== sim.f ====
+incdir+.
cpuPkg.sv
controlDecoder.sv
registerFile.sv
hazardUnit.sv
executeStage.sv
dataMemory.sv
mipsPipeline.sv
mipsPipeline_tb.sv
